//--- bft_pkg.sv
`default_nettype none

package bft_pkg;

    // Packet geometry on the fat-tree links.
    localparam int PACKET_BITS  = 49;
    localparam int PAYLOAD_BITS = 32;
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;

    localparam int CFG_PAD_BITS = PAYLOAD_BITS - LEAF_BITS - PORT_BITS;

    // Data view, vld is the top bit.
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } packet_t;

    // Configuration view of the same word, used on port 0.
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;   // Selects the routing entry.
        logic [CFG_PAD_BITS-1:0] pad;
        logic [LEAF_BITS-1:0]    route_leaf;
        logic [PORT_BITS-1:0]    route_port;
    } cfg_packet_t;

    typedef union packed {
        packet_t     pkt;
        cfg_packet_t cfg;
    } packet_word_u;

endpackage

`default_nettype wire

//--- leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    import bft_pkg::*;

    // User-side stream counts.
    localparam int NUM_IN  = 5;
    localparam int NUM_OUT = 4;

    // One user word with its valid flag.
    typedef struct packed {
        logic                    vld;
        logic [PAYLOAD_BITS-1:0] data;
    } stream_t;

    // Destination of one output stream.
    typedef struct packed {
        logic [LEAF_BITS-1:0] leaf;
        logic [PORT_BITS-1:0] port;
    } route_t;

endpackage

`default_nettype wire

//--- leaf_config.sv
`timescale 1ns/1ns
`default_nettype none

module leaf_config
    import leaf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cfg_wr,
    input  logic [1:0] cfg_sel,
    input  route_t     cfg_route,
    input  logic       ap_start,
    output route_t     routes [NUM_OUT],
    output logic       kernel_rst_n
);

    logic [NUM_OUT-1:0] route_we;

    // One write enable per routing entry.
    always_comb begin
        route_we = '0;
        if (cfg_wr) begin
            route_we[cfg_sel] = 1'b1;
        end
    end

    for (genvar i = 0; i < NUM_OUT; i++) begin : g_route
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                routes[i] <= '0;
            end else if (route_we[i]) begin
                routes[i] <= cfg_route;
            end
        end
    end

    // Kernel stays in reset until the first ap_start.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kernel_rst_n <= 1'b0;
        end else if (ap_start) begin
            kernel_rst_n <= 1'b1;   // Sticky until rst_n.
        end
    end

endmodule

`default_nettype wire

//--- leaf_rx.sv
`timescale 1ns/1ns
`default_nettype none

module leaf_rx
    import bft_pkg::*;
    import leaf_pkg::*;
#(
    parameter logic [LEAF_BITS-1:0] LEAF_ID    = '0,
    parameter int                   FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  packet_word_u      din,
    output logic              cfg_wr,
    output logic [1:0]        cfg_sel,
    output route_t            cfg_route,
    output stream_t           to_user [NUM_IN],
    input  logic [NUM_IN-1:0] ack_from_user
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    packet_word_u din_q;
    logic         din_vld_q;
    logic         hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            din_vld_q <= 1'b0;
        end else begin
            din_vld_q <= din.pkt.vld;
        end
    end

    always_ff @(posedge clk) begin
        din_q <= din;
    end

    assign hit = din_vld_q && (din_q.pkt.leaf == LEAF_ID);

    // Port 0 is a routing-table write.
    assign cfg_wr    = hit && (din_q.cfg.port == '0);
    assign cfg_sel   = din_q.cfg.addr[1:0];
    assign cfg_route = '{leaf: din_q.cfg.route_leaf, port: din_q.cfg.route_port};

    // Ports 1 to 5 each own a small FIFO.
    for (genvar i = 0; i < NUM_IN; i++) begin : g_fifo
        logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
        logic [AW-1:0]           wr_ptr;
        logic [AW-1:0]           rd_ptr;
        logic [CW-1:0]           count;
        logic                    push;
        logic                    pop;

        assign push = hit && (din_q.pkt.port == PORT_BITS'(i + 1))
                      && (count != CW'(FIFO_DEPTH));   // Full FIFO drops the word.
        assign pop  = (count != '0) && ack_from_user[i];

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= din_q.pkt.payload;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) begin
                    wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                end
                if (pop) begin
                    rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        assign to_user[i] = '{vld: (count != '0), data: mem[rd_ptr]};
    end

endmodule

`default_nettype wire

//--- leaf_tx.sv
`timescale 1ns/1ns
`default_nettype none

module leaf_tx
    import bft_pkg::*;
    import leaf_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  stream_t            from_user [NUM_OUT],
    output logic [NUM_OUT-1:0] ack_to_user,
    input  route_t             routes [NUM_OUT],
    input  logic               resend,
    output packet_t            dout
);

    localparam int SW = $clog2(NUM_OUT);

    logic [SW-1:0] last_q;
    logic [SW-1:0] pick;
    logic          found;
    packet_t       pkt;
    packet_t       dout_q;

    // Round-robin search, starting just after the last grant.
    always_comb begin
        logic [SW-1:0] idx;
        found = 1'b0;
        pick  = last_q;
        for (int off = 1; off <= NUM_OUT; off++) begin
            idx = last_q + SW'(off);
            if (!found && from_user[idx].vld) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    // No grant while the network asks for a resend.
    assign ack_to_user = (found && !resend) ? (NUM_OUT'(1) << pick) : '0;

    always_comb begin
        pkt.vld     = 1'b1;
        pkt.leaf    = routes[pick].leaf;
        pkt.port    = routes[pick].port;
        pkt.addr    = ADDR_BITS'(pick) + 1'b1;   // Streams are numbered from 1.
        pkt.payload = from_user[pick].data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_q <= '0;
            last_q <= SW'(NUM_OUT - 1);   // Stream 1 wins first.
        end else if (!resend) begin
            dout_q <= found ? pkt : '0;
            if (found) begin
                last_q <= pick;
            end
        end
    end

    // Held packet is presented again when resend falls.
    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

//--- user_kernel.sv
`timescale 1ns/1ns
`default_nettype none

module user_kernel
    import bft_pkg::*;
    import leaf_pkg::*;
(
    input  logic               clk,
    input  logic               kernel_rst_n,
    input  stream_t            to_user [NUM_IN],
    output logic [NUM_IN-1:0]  ack_from_user,
    output stream_t            from_user [NUM_OUT],
    input  logic [NUM_OUT-1:0] ack_to_user
);

    localparam int OFS = NUM_IN - 1;   // Stream 5 carries the offset.

    logic                    run_q;
    logic [PAYLOAD_BITS-1:0] offset_q;
    logic [NUM_OUT-1:0]      out_vld_q;
    logic [PAYLOAD_BITS-1:0] out_data_q [NUM_OUT];
    logic [NUM_OUT-1:0]      take;

    // Take a word when the output slot is free or being drained.
    always_comb begin
        for (int k = 0; k < NUM_OUT; k++) begin
            take[k] = run_q && to_user[k].vld && (!out_vld_q[k] || ack_to_user[k]);
        end
    end

    assign ack_from_user = {run_q && to_user[OFS].vld, take};

    always_ff @(posedge clk or negedge kernel_rst_n) begin
        if (!kernel_rst_n) begin
            run_q     <= 1'b0;
            offset_q  <= '0;
            out_vld_q <= '0;
        end else begin
            run_q <= 1'b1;
            if (run_q && to_user[OFS].vld) begin
                offset_q <= to_user[OFS].data;
            end
            for (int k = 0; k < NUM_OUT; k++) begin
                if (take[k]) begin
                    out_vld_q[k] <= 1'b1;
                end else if (ack_to_user[k]) begin
                    out_vld_q[k] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_OUT; k++) begin
            if (take[k]) begin
                out_data_q[k] <= to_user[k].data + offset_q;   // Wraps at 32 bits.
            end
        end
    end

    for (genvar k = 0; k < NUM_OUT; k++) begin : g_out
        assign from_user[k] = '{vld: out_vld_q[k], data: out_data_q[k]};
    end

endmodule

`default_nettype wire

//--- leaf_i5o4.sv
`timescale 1ns/1ns
`default_nettype none

module leaf_i5o4
    import bft_pkg::*;
    import leaf_pkg::*;
#(
    parameter logic [LEAF_BITS-1:0] LEAF_ID    = '0,
    parameter int                   FIFO_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  packet_t din,
    output packet_t dout,
    input  logic    resend,
    input  logic    ap_start
);

    logic               cfg_wr;
    logic [1:0]         cfg_sel;
    route_t             cfg_route;
    route_t             routes [NUM_OUT];
    logic               kernel_rst_n;
    stream_t            to_user [NUM_IN];
    logic [NUM_IN-1:0]  ack_from_user;
    stream_t            from_user [NUM_OUT];
    logic [NUM_OUT-1:0] ack_to_user;

    leaf_config u_leaf_config (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_wr       (cfg_wr),
        .cfg_sel      (cfg_sel),
        .cfg_route    (cfg_route),
        .ap_start     (ap_start),
        .routes       (routes),
        .kernel_rst_n (kernel_rst_n)
    );

    // Network word is decoded in both views inside the receiver.
    leaf_rx #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_leaf_rx (
        .clk           (clk),
        .rst_n         (rst_n),
        .din           (din),
        .cfg_wr        (cfg_wr),
        .cfg_sel       (cfg_sel),
        .cfg_route     (cfg_route),
        .to_user       (to_user),
        .ack_from_user (ack_from_user)
    );

    user_kernel u_user_kernel (
        .clk           (clk),
        .kernel_rst_n  (kernel_rst_n),
        .to_user       (to_user),
        .ack_from_user (ack_from_user),
        .from_user     (from_user),
        .ack_to_user   (ack_to_user)
    );

    leaf_tx u_leaf_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .from_user   (from_user),
        .ack_to_user (ack_to_user),
        .routes      (routes),
        .resend      (resend),
        .dout        (dout)
    );

endmodule

`default_nettype wire

//--- tb_leaf_i5o4.sv
`timescale 1ns/1ns
`default_nettype none

module tb_leaf_i5o4
    import bft_pkg::*;
    import leaf_pkg::*;
();

    localparam logic [LEAF_BITS-1:0] LEAF_ID = 5'd3;
    localparam int TIMEOUT = 200;   // Cycles allowed for expected packets.
    localparam int QUIET   = 20;    // Extra cycles to catch duplicates.

    logic    clk;
    logic    rst_n;
    packet_t din;
    packet_t dout;
    logic    resend;
    logic    ap_start;

    packet_t                 rx_q [$];   // Packets seen on dout.
    packet_t                 exp_q [$];  // Packets still expected.
    route_t                  route_model [NUM_OUT];
    logic [PAYLOAD_BITS-1:0] offset_model;
    int                      errors;
    int                      timeouts;
    int                      packets_seen;

    leaf_i5o4 #(
        .LEAF_ID    (LEAF_ID),
        .FIFO_DEPTH (4)
    ) u_leaf_i5o4 (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .dout     (dout),
        .resend   (resend),
        .ap_start (ap_start)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // dout is registered, so the posedge value is the one held all last cycle.
    always @(posedge clk) begin
        if (resend) begin
            assert (dout == '0) else begin
                $display("FAIL %0t ns: dout is %h while resend is high", $time, dout);
                errors++;
            end
        end
        if (dout.vld) begin
            rx_q.push_back(dout);
            packets_seen++;
        end
    end

    task automatic send_packet(input logic vld, input logic [LEAF_BITS-1:0] leaf,
                               input logic [PORT_BITS-1:0] port,
                               input logic [ADDR_BITS-1:0] addr,
                               input logic [PAYLOAD_BITS-1:0] payload);
        @(negedge clk);
        din = '{vld: vld, leaf: leaf, port: port, addr: addr, payload: payload};
    endtask

    task automatic release_din();
        @(negedge clk);
        din = '0;
    endtask

    // Data word for stream 1 to 4, with the packet it should turn into.
    task automatic send_data(input int stream, input logic [PAYLOAD_BITS-1:0] data);
        packet_t want;
        want.vld     = 1'b1;
        want.leaf    = route_model[stream-1].leaf;
        want.port    = route_model[stream-1].port;
        want.addr    = ADDR_BITS'(stream);
        want.payload = data + offset_model;
        exp_q.push_back(want);
        send_packet(1'b1, LEAF_ID, PORT_BITS'(stream), '0, data);
    endtask

    task automatic send_offset(input logic [PAYLOAD_BITS-1:0] value);
        offset_model = value;
        send_packet(1'b1, LEAF_ID, 4'd5, '0, value);
    endtask

    task automatic write_route(input int sel, input logic [LEAF_BITS-1:0] leaf,
                               input logic [PORT_BITS-1:0] port);
        route_model[sel] = '{leaf: leaf, port: port};
        send_packet(1'b1, LEAF_ID, 4'd0, ADDR_BITS'(sel), {23'd0, leaf, port});
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        assert (rx_q.size() == 0) else begin
            $display("FAIL %0t ns: %0d packets on dout, none expected", $time, rx_q.size());
            errors++;
        end
        rx_q.delete();
    endtask

    // Any order across streams, input order within a stream.
    task automatic check_received();
        packet_t got;
        int      idx;
        foreach (rx_q[i]) begin
            got = rx_q[i];
            idx = -1;
            foreach (exp_q[j]) begin
                if (idx < 0 && exp_q[j].addr == got.addr) begin
                    idx = j;
                end
            end
            assert (idx >= 0) else begin
                $display("FAIL %0t ns: unexpected packet %h", $time, got);
                errors++;
            end
            if (idx >= 0) begin
                assert (got == exp_q[idx]) else begin
                    $display("FAIL %0t ns: stream %0d got %h, expected %h",
                             $time, got.addr, got, exp_q[idx]);
                    errors++;
                end
                exp_q.delete(idx);
            end
        end
        assert (exp_q.size() == 0) else begin
            $display("FAIL %0t ns: %0d expected packets never arrived", $time, exp_q.size());
            errors++;
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic collect_and_check();
        int cycles;
        cycles = 0;
        while (rx_q.size() < exp_q.size() && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rx_q.size() < exp_q.size()) begin
            $display("Timeout: only %0d of %0d packets arrived on dout",
                     rx_q.size(), exp_q.size());
            timeouts++;
        end else begin
            repeat (QUIET) @(negedge clk);
        end
        check_received();
    endtask

    task automatic hold_until_start();
        send_data(1, $urandom());
        release_din();
        expect_quiet(40);   // Kernel still in reset.
        @(negedge clk);
        ap_start = 1'b1;
        @(negedge clk);
        ap_start = 1'b0;
        collect_and_check();
    endtask

    task automatic route_each_stream();
        for (int s = 0; s < NUM_OUT; s++) begin
            write_route(s, LEAF_BITS'(8 + s), PORT_BITS'(2 + 3 * s));
        end
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, $urandom());
        end
        release_din();
        collect_and_check();
    endtask

    task automatic add_offset();
        send_offset($urandom());
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, $urandom());
        end
        release_din();
        collect_and_check();
    endtask

    task automatic drop_foreign_packets();
        send_packet(1'b1, 5'd7, 4'd1, '0, $urandom());
        send_packet(1'b1, 5'd7, 4'd0, '0, 32'h0000_01ff);   // Config for another leaf.
        send_packet(1'b0, LEAF_ID, 4'd2, '0, $urandom());
        send_packet(1'b0, LEAF_ID, 4'd0, 7'd1, 32'h0000_01ff);
        release_din();
        expect_quiet(30);
        send_data(1, $urandom());
        send_data(2, $urandom());
        release_din();
        collect_and_check();
    endtask

    task automatic stall_on_resend();
        @(negedge clk);
        resend = 1'b1;
        for (int k = 1; k <= NUM_OUT; k++) begin
            send_data(k, $urandom());
        end
        release_din();
        expect_quiet(30);
        @(negedge clk);
        resend = 1'b0;
        collect_and_check();
    endtask

    task automatic drain_under_load();
        for (int k = 1; k <= NUM_OUT; k++) begin
            for (int w = 0; w < 4; w++) begin
                send_data(k, $urandom());
            end
        end
        release_din();
        collect_and_check();
    endtask

    initial begin
        void'($urandom(32'haa92_6983));
        rst_n        = 1'b0;
        din          = '0;
        resend       = 1'b0;
        ap_start     = 1'b0;
        offset_model = '0;
        errors       = 0;
        timeouts     = 0;
        packets_seen = 0;
        for (int s = 0; s < NUM_OUT; s++) begin
            route_model[s] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        hold_until_start();
        route_each_stream();
        add_offset();
        drop_foreign_packets();
        stall_on_resend();
        drain_under_load();

        $display("errors: %0d, timeouts: %0d, packets seen: %0d",
                 errors, timeouts, packets_seen);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
bft_pkg.sv
leaf_pkg.sv
leaf_config.sv
leaf_rx.sv
leaf_tx.sv
user_kernel.sv
leaf_i5o4.sv
tb_leaf_i5o4.sv

//--- Makefile
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_leaf_i5o4: filelist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_leaf_i5o4 -o Vtb_leaf_i5o4

run: obj_dir/Vtb_leaf_i5o4
	./obj_dir/Vtb_leaf_i5o4 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
